//--- filelist.f
hdl/video_timing_pkg.sv
hdl/pixel_pkg.sv
hdl/scan_if.sv
hdl/vga_timing.sv
hdl/frame_fill_writer.sv
hdl/frame_buffer.sv
hdl/pixel_output.sv
hdl/vga_frame_top.sv
bench/tb_vga_frame.sv

//--- Bender.yml
package:
  name: vga_frame

sources:
  - hdl/video_timing_pkg.sv
  - hdl/pixel_pkg.sv
  - hdl/scan_if.sv
  - hdl/vga_timing.sv
  - hdl/frame_fill_writer.sv
  - hdl/frame_buffer.sv
  - hdl/pixel_output.sv
  - hdl/vga_frame_top.sv
  - target: test
    files:
      - bench/tb_vga_frame.sv

//--- bench/tb_vga_frame.sv
`timescale 1ns/1ps

module tb_vga_frame;

	////////////////////////////////////////
	// Small frame
	////////////////////////////////////////

	localparam int H_ACTIVE     = 15;
	localparam int H_FRONT      = 2;
	localparam int H_PULSE      = 3;
	localparam int H_BACK       = 2;
	localparam int V_ACTIVE     = 11;
	localparam int V_FRONT      = 1;
	localparam int V_PULSE      = 1;
	localparam int V_BACK       = 1;
	localparam int BORDER_INSET = 3;

	// Each phase lasts its last count plus one
	localparam int LINE_PERIOD   = (H_ACTIVE + 1) + (H_FRONT + 1) + (H_PULSE + 1) + (H_BACK + 1);
	localparam int FRAME_LINES   = (V_ACTIVE + 1) + (V_FRONT + 1) + (V_PULSE + 1) + (V_BACK + 1);
	localparam int FRAME_PERIOD  = LINE_PERIOD * FRAME_LINES;
	localparam int ACTIVE_PIXELS = (H_ACTIVE + 1) * (V_ACTIVE + 1);

	localparam int RESET_CYCLES   = 2;
	// Four frames plus two lines of slack
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * FRAME_PERIOD + 2 * LINE_PERIOD;

	// Stored colours, 3-3-2
	localparam logic [7:0] RED_332    = 8'b111_000_00;
	localparam logic [7:0] GREEN_332  = 8'b000_111_00;
	localparam logic [7:0] BLUE_332   = 8'b000_000_11;
	localparam logic [7:0] YELLOW_332 = 8'b111_111_00;
	localparam logic [7:0] WHITE_332  = 8'b111_111_11;

	// Pixel classes
	localparam int CLASS_ILLEGAL      = -1;
	localparam int CLASS_BLACK        = 0;
	localparam int CLASS_WHITE        = 1;
	localparam int CLASS_TOP_LEFT     = 2;
	localparam int CLASS_BOTTOM_LEFT  = 3;
	localparam int CLASS_TOP_RIGHT    = 4;
	localparam int CLASS_BOTTOM_RIGHT = 5;
	localparam int NUM_CLASSES        = 6;

	// Test numbers
	localparam int T_HSYNC   = 0;
	localparam int T_VSYNC   = 1;
	localparam int T_BLANK   = 2;
	localparam int T_LEGAL   = 3;
	localparam int T_COUNTS  = 4;
	localparam int T_TOTAL   = 5;
	localparam int NUM_TESTS = 6;

	logic                M10k_pll;
	logic                reset;
	pixel_pkg::channel_t vga_r;
	pixel_pkg::channel_t vga_g;
	pixel_pkg::channel_t vga_b;
	logic                vga_hs;
	logic                vga_vs;
	logic                vga_blank_n;

	// Bookkeeping
	int    cycle_count = 0;
	int    check_count [NUM_TESTS];
	int    error_count [NUM_TESTS];
	bit    reported [NUM_TESTS];
	string test_name [NUM_TESTS];
	bit    run_done = 1'b0;
	bit    timed_out = 1'b0;

	// Sync monitor state
	logic hs_prev;
	logic sync_and_prev;
	int   hs_low_len = 0;
	int   hs_last_fall = -1;

	// Frame monitor state
	logic vs_prev;
	int   vs_low_len = 0;
	int   vs_last_fall = -1;
	int   vs_falls = 0;
	bit   window_open = 1'b0;
	int   color_count [NUM_CLASSES];

	vga_frame_top #(
		.H_ACTIVE     (H_ACTIVE),
		.H_FRONT      (H_FRONT),
		.H_PULSE      (H_PULSE),
		.H_BACK       (H_BACK),
		.V_ACTIVE     (V_ACTIVE),
		.V_FRONT      (V_FRONT),
		.V_PULSE      (V_PULSE),
		.V_BACK       (V_BACK),
		.BORDER_INSET (BORDER_INSET)
	) DUT (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_blank_n (vga_blank_n)
	);

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Each field into the top of its channel
	function automatic logic [23:0] expand_332(input logic [7:0] c);
		return {c[7:5], 5'b0, c[4:2], 5'b0, c[1:0], 6'b0};
	endfunction

	// X or unknown values fall through to illegal
	function automatic int classify_pixel(input logic [23:0] rgb);
		if (rgb === 24'h0) return CLASS_BLACK;
		if (rgb === expand_332(WHITE_332)) return CLASS_WHITE;
		if (rgb === expand_332(RED_332)) return CLASS_TOP_LEFT;
		if (rgb === expand_332(GREEN_332)) return CLASS_BOTTOM_LEFT;
		if (rgb === expand_332(BLUE_332)) return CLASS_TOP_RIGHT;
		if (rgb === expand_332(YELLOW_332)) return CLASS_BOTTOM_RIGHT;
		return CLASS_ILLEGAL;
	endfunction

	// Pixels of one class over the active area
	function automatic int expected_count(input int cls);
		int  count;
		bit  on_border;
		bit  left;
		bit  top;
		int  pixel_class;
		count = 0;
		for (int y = 0; y <= V_ACTIVE; y++) begin
			for (int x = 0; x <= H_ACTIVE; x++) begin
				// Four inset lines
				on_border = (x == BORDER_INSET) || (x == H_ACTIVE - BORDER_INSET) ||
					(y == BORDER_INSET) || (y == V_ACTIVE - BORDER_INSET);
				left = (x < (H_ACTIVE + 1) / 2);
				top  = (y < (V_ACTIVE + 1) / 2);
				if (on_border) begin
					pixel_class = CLASS_WHITE;
				end else if (left) begin
					pixel_class = top ? CLASS_TOP_LEFT : CLASS_BOTTOM_LEFT;
				end else begin
					pixel_class = top ? CLASS_TOP_RIGHT : CLASS_BOTTOM_RIGHT;
				end
				if (pixel_class == cls) begin
					count++;
				end
			end
		end
		return count;
	endfunction

	////////////////////////////////////////
	// Check and report helpers
	////////////////////////////////////////

	task automatic expect_equal(
		input int          test,
		input string       signal,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		check_count[test]++;
		assert (actual === expected) else begin
			$display("[FAIL] %0t %s: expected %0d, got %0d", $time, signal, expected, actual);
			error_count[test]++;
		end
	endtask

	task automatic report_test(input int test);
		if (!reported[test]) begin
			reported[test] = 1'b1;
			if (check_count[test] == 0) begin
				$display("%s: no check was reached", test_name[test]);
				error_count[test]++;
			end else if (error_count[test] == 0) begin
				$display("%s: %0d checks, ok", test_name[test], check_count[test]);
			end else begin
				$display("%s: %0d checks, %0d errors", test_name[test],
					check_count[test], error_count[test]);
			end
		end
	endtask

	// End of one vsync-to-vsync window
	task automatic close_window();
		int total;
		total = 0;
		for (int c = CLASS_WHITE; c < NUM_CLASSES; c++) begin
			total += color_count[c];
		end
		// Window one holds the second frame
		if (vs_falls == 2) begin
			expect_equal(T_COUNTS, "vga_rgb white count",
				expected_count(CLASS_WHITE), color_count[CLASS_WHITE]);
			expect_equal(T_COUNTS, "vga_rgb red count",
				expected_count(CLASS_TOP_LEFT), color_count[CLASS_TOP_LEFT]);
			expect_equal(T_COUNTS, "vga_rgb green count",
				expected_count(CLASS_BOTTOM_LEFT), color_count[CLASS_BOTTOM_LEFT]);
			expect_equal(T_COUNTS, "vga_rgb blue count",
				expected_count(CLASS_TOP_RIGHT), color_count[CLASS_TOP_RIGHT]);
			expect_equal(T_COUNTS, "vga_rgb yellow count",
				expected_count(CLASS_BOTTOM_RIGHT), color_count[CLASS_BOTTOM_RIGHT]);
			report_test(T_COUNTS);
		end
		expect_equal(T_TOTAL, "vga_rgb nonzero count", ACTIVE_PIXELS, total);
		for (int c = 0; c < NUM_CLASSES; c++) begin
			color_count[c] = 0;
		end
	endtask

	////////////////////////////////////////
	// Clock, cycle counter
	////////////////////////////////////////

	initial begin
		M10k_pll = 1'b0;
		forever begin
			#50 M10k_pll = ~M10k_pll;
		end
	end

	always @(posedge M10k_pll) begin
		cycle_count <= cycle_count + 1;
	end

	////////////////////////////////////////
	// Monitors, sampled mid-cycle
	////////////////////////////////////////

	// Horizontal sync and blank
	always @(negedge M10k_pll) begin
		if (cycle_count > RESET_CYCLES) begin
			// Blank is last cycle's sync AND
			expect_equal(T_BLANK, "vga_blank_n", sync_and_prev, vga_blank_n);
			if (hs_prev && !vga_hs) begin
				if (hs_last_fall >= 0) begin
					expect_equal(T_HSYNC, "vga_hs fall interval", LINE_PERIOD,
						cycle_count - hs_last_fall);
				end
				hs_last_fall = cycle_count;
			end
			if (!vga_hs) begin
				hs_low_len++;
			end else if (!hs_prev) begin
				// Pulse just ended
				if (hs_last_fall >= 0) begin
					expect_equal(T_HSYNC, "vga_hs low width", H_PULSE + 1, hs_low_len);
				end
				hs_low_len = 0;
			end
		end
		hs_prev       = vga_hs;
		sync_and_prev = vga_hs & vga_vs;
	end

	// Vertical sync, pixel colours and counts
	always @(negedge M10k_pll) begin : frame_monitor
		int cls;
		if (cycle_count > RESET_CYCLES && !run_done) begin
			cls = classify_pixel({vga_r, vga_g, vga_b});
			// Buffer is full from the first vsync on
			if (window_open) begin
				check_count[T_LEGAL]++;
				assert (cls != CLASS_ILLEGAL) else begin
					$display("[FAIL] %0t vga_r/vga_g/vga_b: expected %s, got %h %h %h",
						$time, "black, white or a quadrant colour", vga_r, vga_g, vga_b);
					error_count[T_LEGAL]++;
				end
				if (cls > CLASS_BLACK) begin
					color_count[cls]++;
				end
			end
			if (!vga_vs) begin
				vs_low_len++;
			end else if (!vs_prev) begin
				if (vs_last_fall >= 0) begin
					expect_equal(T_VSYNC, "vga_vs low width", (V_PULSE + 1) * LINE_PERIOD,
						vs_low_len);
				end
				vs_low_len = 0;
			end
			if (vs_prev && !vga_vs) begin
				vs_falls++;
				if (vs_last_fall >= 0) begin
					expect_equal(T_VSYNC, "vga_vs fall interval", FRAME_PERIOD,
						cycle_count - vs_last_fall);
				end
				vs_last_fall = cycle_count;
				if (window_open) begin
					close_window();
				end
				window_open = 1'b1;
				// Two full windows seen
				if (vs_falls == 3) begin
					run_done = 1'b1;
				end
			end
		end
		vs_prev = vga_vs;
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int failed;
		int checks;
		test_name[T_HSYNC]  = "hsync timing";
		test_name[T_VSYNC]  = "vsync timing";
		test_name[T_BLANK]  = "blank timing";
		test_name[T_LEGAL]  = "colour values";
		test_name[T_COUNTS] = "colour counts";
		test_name[T_TOTAL]  = "active pixel count";
		failed = 0;
		checks = 0;
		reset  = 1'b1;
		repeat (RESET_CYCLES) @(negedge M10k_pll);
		reset = 1'b0;

		while (!run_done && cycle_count < TIMEOUT_CYCLES) begin
			@(posedge M10k_pll);
		end
		if (!run_done) begin
			$display("Timeout: the third vsync pulse did not arrive within %0d cycles",
				TIMEOUT_CYCLES);
			timed_out = 1'b1;
		end

		for (int t = 0; t < NUM_TESTS; t++) begin
			report_test(t);
			checks += check_count[t];
			if (error_count[t] != 0) begin
				failed++;
			end
		end
		$display("Tests: %0d, passed: %0d, failed: %0d, checks: %0d",
			NUM_TESTS, NUM_TESTS - failed, failed, checks);
		if (failed == 0 && !timed_out) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- hdl/vga_frame_top.sv
`timescale 1ns/1ps

module vga_frame_top #(
	// Horizontal phases, last count in clocks
	parameter int H_ACTIVE     = 639,
	parameter int H_FRONT      = 15,
	parameter int H_PULSE      = 95,
	parameter int H_BACK       = 47,
	// Vertical phases, last count in lines
	parameter int V_ACTIVE     = 479,
	parameter int V_FRONT      = 9,
	parameter int V_PULSE      = 1,
	parameter int V_BACK       = 32,
	// Border distance from each edge
	parameter int BORDER_INSET = 100
) (
	input  logic                M10k_pll,
	input  logic                reset,
	output pixel_pkg::channel_t vga_r,
	output pixel_pkg::channel_t vga_g,
	output pixel_pkg::channel_t vga_b,
	output logic                vga_hs,
	output logic                vga_vs,
	output logic                vga_blank_n
);

	// Enough address bits for one full frame
	localparam int ADDR_W = $clog2((H_ACTIVE + 1) * (V_ACTIVE + 1));

	////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////

	// Write port
	logic               write_enable;
	logic [ADDR_W-1:0]  write_address;
	pixel_pkg::rgb332_t write_data;

	// Read port
	logic [ADDR_W-1:0]  read_address;
	pixel_pkg::rgb332_t read_data;

	// Scan position and syncs
	scan_if scan ();

	////////////////////////////////////////
	// Blocks
	////////////////////////////////////////

	vga_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_PULSE  (H_PULSE),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_PULSE  (V_PULSE),
		.V_BACK   (V_BACK)
	) u_vga_timing (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.scan     (scan.source)
	);

	frame_fill_writer #(
		.H_ACTIVE (H_ACTIVE),
		.V_ACTIVE (V_ACTIVE),
		.ADDR_W   (ADDR_W)
	) u_frame_fill_writer (
		.M10k_pll      (M10k_pll),
		.reset         (reset),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data)
	);

	frame_buffer #(
		.ADDR_W (ADDR_W)
	) u_frame_buffer (
		.M10k_pll      (M10k_pll),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data),
		.read_address  (read_address),
		.read_data     (read_data)
	);

	pixel_output #(
		.H_ACTIVE     (H_ACTIVE),
		.V_ACTIVE     (V_ACTIVE),
		.BORDER_INSET (BORDER_INSET),
		.ADDR_W       (ADDR_W)
	) u_pixel_output (
		.M10k_pll     (M10k_pll),
		.reset        (reset),
		.scan         (scan.sink),
		.read_address (read_address),
		.read_data    (read_data),
		.vga_r        (vga_r),
		.vga_g        (vga_g),
		.vga_b        (vga_b),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs),
		.vga_blank_n  (vga_blank_n)
	);

endmodule

//--- hdl/pixel_output.sv
`timescale 1ns/1ps

module pixel_output #(
	parameter int H_ACTIVE     = 639,
	parameter int V_ACTIVE     = 479,
	parameter int BORDER_INSET = 100,
	parameter int ADDR_W       = 19
) (
	input  logic                M10k_pll,
	input  logic                reset,
	scan_if.sink                scan,
	output logic [ADDR_W-1:0]   read_address,
	input  pixel_pkg::rgb332_t  read_data,
	output pixel_pkg::channel_t vga_r,
	output pixel_pkg::channel_t vga_g,
	output pixel_pkg::channel_t vga_b,
	output logic                vga_hs,
	output logic                vga_vs,
	output logic                vga_blank_n
);

	localparam int LINE_W = H_ACTIVE + 1;

	// Border lines, inset from each edge
	localparam video_timing_pkg::coord_t LEFT_X   = video_timing_pkg::coord_t'(BORDER_INSET);
	localparam video_timing_pkg::coord_t RIGHT_X  =
		video_timing_pkg::coord_t'(H_ACTIVE - BORDER_INSET);
	localparam video_timing_pkg::coord_t TOP_Y    = video_timing_pkg::coord_t'(BORDER_INSET);
	localparam video_timing_pkg::coord_t BOTTOM_Y =
		video_timing_pkg::coord_t'(V_ACTIVE - BORDER_INSET);

	logic               on_border;
	// Stage one, aligned with the read data
	logic               active_d;
	logic               border_d;
	// Colour picked for the output register
	pixel_pkg::rgb332_t shown;

	// Same layout as the writer
	assign read_address = ADDR_W'(scan.next_y) * ADDR_W'(LINE_W) + ADDR_W'(scan.next_x);

	assign on_border = (scan.next_x == LEFT_X) || (scan.next_x == RIGHT_X) ||
			(scan.next_y == TOP_Y) || (scan.next_y == BOTTOM_Y);

	////////////////////////////////////////
	// Stage one
	////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			active_d <= 1'b0;
			border_d <= 1'b0;
			vga_hs   <= 1'b1;
			vga_vs   <= 1'b1;
		end else begin
			active_d <= scan.in_active;
			border_d <= on_border;
			// Syncs leave here, lined up with the pixel colour
			vga_hs   <= scan.hsync;
			vga_vs   <= scan.vsync;
		end
	end

	// Black in blanking, border on top of the picture
	always_comb begin
		if (!active_d) begin
			shown = '0;
		end else if (border_d) begin
			shown = pixel_pkg::COLOR_BORDER;
		end else begin
			shown = read_data;
		end
	end

	////////////////////////////////////////
	// Stage two
	////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			vga_r       <= '0;
			vga_g       <= '0;
			vga_b       <= '0;
			vga_blank_n <= 1'b0;
		end else begin
			// Fields into the top bits, low bits zero
			vga_r <= {shown.red, {(pixel_pkg::CHANNEL_W - pixel_pkg::RED_W){1'b0}}};
			vga_g <= {shown.green, {(pixel_pkg::CHANNEL_W - pixel_pkg::GREEN_W){1'b0}}};
			vga_b <= {shown.blue, {(pixel_pkg::CHANNEL_W - pixel_pkg::BLUE_W){1'b0}}};
			vga_blank_n <= vga_hs & vga_vs;
		end
	end

endmodule

//--- hdl/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
	parameter int ADDR_W = 19
) (
	input  logic                M10k_pll,
	input  logic                write_enable,
	input  logic [ADDR_W-1:0]   write_address,
	input  pixel_pkg::rgb332_t  write_data,
	input  logic [ADDR_W-1:0]   read_address,
	output pixel_pkg::rgb332_t  read_data
);

	// One word per pixel
	localparam int DEPTH = 2 ** ADDR_W;

	pixel_pkg::rgb332_t mem [DEPTH];

	////////////////////////////////////////
	// Block RAM, old data on collision
	////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (write_enable) begin
			mem[write_address] <= write_data;
		end
		// Registered read
		read_data <= mem[read_address];
	end

endmodule

//--- hdl/frame_fill_writer.sv
`timescale 1ns/1ps

module frame_fill_writer #(
	parameter int H_ACTIVE = 639,
	parameter int V_ACTIVE = 479,
	parameter int ADDR_W   = 19
) (
	input  logic                M10k_pll,
	input  logic                reset,
	output logic                write_enable,
	output logic [ADDR_W-1:0]   write_address,
	output pixel_pkg::rgb332_t  write_data
);

	// Pixels per line
	localparam int LINE_W = H_ACTIVE + 1;

	// Quadrant split points
	localparam video_timing_pkg::coord_t HALF_X = video_timing_pkg::coord_t'((H_ACTIVE + 1) / 2);
	localparam video_timing_pkg::coord_t HALF_Y = video_timing_pkg::coord_t'((V_ACTIVE + 1) / 2);

	// Sweep position
	video_timing_pkg::coord_t x;
	video_timing_pkg::coord_t y;

	// Quadrant colour at the sweep position
	pixel_pkg::rgb332_t fill_color;

	always_comb begin
		if (x < HALF_X) begin
			fill_color = (y < HALF_Y) ? pixel_pkg::COLOR_TOP_LEFT :
					pixel_pkg::COLOR_BOTTOM_LEFT;
		end else begin
			fill_color = (y < HALF_Y) ? pixel_pkg::COLOR_TOP_RIGHT :
					pixel_pkg::COLOR_BOTTOM_RIGHT;
		end
	end

	////////////////////////////////////////
	// Raster sweep, one write per clock
	////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			write_enable <= 1'b0;
			x            <= '0;
			y            <= '0;
		end else begin
			write_enable <= 1'b1;
			// Wrap at end of line, then at end of frame
			if (x == video_timing_pkg::coord_t'(H_ACTIVE)) begin
				x <= '0;
				y <= (y == video_timing_pkg::coord_t'(V_ACTIVE)) ? '0 : y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// Address and data follow the sweep
	always_ff @(posedge M10k_pll) begin
		write_address <= ADDR_W'(y) * ADDR_W'(LINE_W) + ADDR_W'(x);
		write_data    <= fill_color;
	end

endmodule

//--- hdl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
	// Last count of each horizontal phase, in clocks
	parameter int H_ACTIVE = 639,
	parameter int H_FRONT  = 15,
	parameter int H_PULSE  = 95,
	parameter int H_BACK   = 47,
	// Last count of each vertical phase, in lines
	parameter int V_ACTIVE = 479,
	parameter int V_FRONT  = 9,
	parameter int V_PULSE  = 1,
	parameter int V_BACK   = 32
) (
	input  logic     M10k_pll,
	input  logic     reset,
	scan_if.source   scan
);

	////////////////////////////////////////
	// Phase helpers
	////////////////////////////////////////

	// Phase order ACTIVE, FRONT, PULSE, BACK, then back to ACTIVE
	function automatic video_timing_pkg::scan_phase_e next_phase(
		input video_timing_pkg::scan_phase_e phase
	);
		case (phase)
			video_timing_pkg::ACTIVE: return video_timing_pkg::FRONT;
			video_timing_pkg::FRONT:  return video_timing_pkg::PULSE;
			video_timing_pkg::PULSE:  return video_timing_pkg::BACK;
			default:                  return video_timing_pkg::ACTIVE;
		endcase
	endfunction

	// Final horizontal count of a phase
	function automatic video_timing_pkg::coord_t h_last(
		input video_timing_pkg::scan_phase_e phase
	);
		case (phase)
			video_timing_pkg::ACTIVE: return video_timing_pkg::coord_t'(H_ACTIVE);
			video_timing_pkg::FRONT:  return video_timing_pkg::coord_t'(H_FRONT);
			video_timing_pkg::PULSE:  return video_timing_pkg::coord_t'(H_PULSE);
			default:                  return video_timing_pkg::coord_t'(H_BACK);
		endcase
	endfunction

	// Final vertical count of a phase
	function automatic video_timing_pkg::coord_t v_last(
		input video_timing_pkg::scan_phase_e phase
	);
		case (phase)
			video_timing_pkg::ACTIVE: return video_timing_pkg::coord_t'(V_ACTIVE);
			video_timing_pkg::FRONT:  return video_timing_pkg::coord_t'(V_FRONT);
			video_timing_pkg::PULSE:  return video_timing_pkg::coord_t'(V_PULSE);
			default:                  return video_timing_pkg::coord_t'(V_BACK);
		endcase
	endfunction

	// Phase state and counters
	video_timing_pkg::scan_phase_e h_phase;
	video_timing_pkg::scan_phase_e v_phase;
	video_timing_pkg::coord_t      h_count;
	video_timing_pkg::coord_t      v_count;

	// Last count of the current phase reached
	logic h_end;
	logic v_end;
	// Final clock of the line
	logic line_done;

	// Sync registers
	logic hsync_q;
	logic vsync_q;

	assign h_end     = (h_count == h_last(h_phase));
	assign v_end     = (v_count == v_last(v_phase));
	assign line_done = (h_phase == video_timing_pkg::BACK) && h_end;

	////////////////////////////////////////
	// Horizontal
	////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			h_phase <= video_timing_pkg::ACTIVE;
			h_count <= '0;
			hsync_q <= 1'b1;
		end else begin
			// Counter restarts at every phase change
			if (h_end) begin
				h_count <= '0;
				h_phase <= next_phase(h_phase);
			end else begin
				h_count <= h_count + 1'b1;
			end
			// Low only through the pulse, one clock late
			hsync_q <= (h_phase != video_timing_pkg::PULSE);
		end
	end

	////////////////////////////////////////
	// Vertical
	////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			v_phase <= video_timing_pkg::ACTIVE;
			v_count <= '0;
			vsync_q <= 1'b1;
		end else begin
			// Steps once per line
			if (line_done) begin
				if (v_end) begin
					v_count <= '0;
					v_phase <= next_phase(v_phase);
				end else begin
					v_count <= v_count + 1'b1;
				end
			end
			vsync_q <= (v_phase != video_timing_pkg::PULSE);
		end
	end

	// Coordinates of the pixel being scanned
	assign scan.next_x    = (h_phase == video_timing_pkg::ACTIVE) ? h_count : '0;
	assign scan.next_y    = (v_phase == video_timing_pkg::ACTIVE) ? v_count : '0;
	assign scan.in_active = (h_phase == video_timing_pkg::ACTIVE) &&
				(v_phase == video_timing_pkg::ACTIVE);
	assign scan.hsync     = hsync_q;
	assign scan.vsync     = vsync_q;

endmodule

//--- hdl/scan_if.sv
`timescale 1ns/1ps

interface scan_if;

	// Coordinates of the pixel to fetch next
	// Held at zero outside the active phase
	video_timing_pkg::coord_t next_x;
	video_timing_pkg::coord_t next_y;

	// Both axes in ACTIVE
	logic in_active;

	// Registered syncs, active low
	logic hsync;
	logic vsync;

	// Timing generator side
	modport source (output next_x, next_y, in_active, hsync, vsync);

	// Pixel output side
	modport sink (input next_x, next_y, in_active, hsync, vsync);

endinterface

//--- hdl/pixel_pkg.sv
package pixel_pkg;

	////////////////////////////////////////
	// Field and channel widths
	////////////////////////////////////////

	localparam int RED_W     = 3;
	localparam int GREEN_W   = 3;
	localparam int BLUE_W    = 2;
	// DAC channel width
	localparam int CHANNEL_W = 8;

	// One DAC channel
	typedef logic [CHANNEL_W-1:0] channel_t;

	// Stored pixel in 3-3-2, red in the top bits
	typedef struct packed {
		logic [RED_W-1:0]   red;
		logic [GREEN_W-1:0] green;
		logic [BLUE_W-1:0]  blue;
	} rgb332_t;

	////////////////////////////////////////
	// Fixed colours
	////////////////////////////////////////

	// Quadrant fill
	localparam rgb332_t COLOR_TOP_LEFT     = '{red: 3'b111, green: 3'b000, blue: 2'b00};
	localparam rgb332_t COLOR_BOTTOM_LEFT  = '{red: 3'b000, green: 3'b111, blue: 2'b00};
	localparam rgb332_t COLOR_TOP_RIGHT    = '{red: 3'b000, green: 3'b000, blue: 2'b11};
	localparam rgb332_t COLOR_BOTTOM_RIGHT = '{red: 3'b111, green: 3'b111, blue: 2'b00};

	// Border overlay, full white
	localparam rgb332_t COLOR_BORDER = '1;

endpackage

//--- hdl/video_timing_pkg.sv
package video_timing_pkg;

	////////////////////////////////////////
	// Scan coordinates
	////////////////////////////////////////

	// Wide enough for 640x480 and its blanking
	localparam int COORD_W = 10;

	// Pixel column or line number
	typedef logic [COORD_W-1:0] coord_t;

	////////////////////////////////////////
	// Scan phases
	////////////////////////////////////////

	// Same four phases on both axes
	// Horizontal counts in clocks, vertical in lines
	typedef enum logic [1:0] {
		// Visible pixels
		ACTIVE = 2'd0,
		// Blank before sync
		FRONT  = 2'd1,
		// Sync low
		PULSE  = 2'd2,
		// Blank after sync
		BACK   = 2'd3
	} scan_phase_e;

endpackage
